/* logic/flash_cmd_decoder.sv */
`timescale 1ns/1ps

`include "spi_flash_config.svh"

module flash_cmd_decoder
    import spi_flash_pkg::*;
(
    input  logic       sclk,
    input  logic       cs,
    input  logic [7:0] rx_byte,
    input  logic       rx_last,
    output reply_sel_e reply_sel,
    output logic       addr_load,
    output logic       bad_cmd
);

    localparam int ADDR_BYTES  = `FLASH_ADDR_BYTES;
    localparam int DUMMY_BYTES = `FLASH_DUMMY_BYTES;
    localparam int DUMMY_W     = (DUMMY_BYTES > 1) ? $clog2(DUMMY_BYTES) : 1;

    // Phase encoding puts address byte n at value n.
    localparam flash_phase_e LAST_ADDR = flash_phase_e'(ADDR_BYTES);

    flash_phase_e       phase;
    flash_phase_e       phase_nxt;
    logic [DUMMY_W-1:0] dummy_cnt;
    logic [DUMMY_W-1:0] dummy_nxt;
    logic               bad_nxt;

    // **************************************************************************
    // Byte boundary decode
    // **************************************************************************

    always_comb begin
        phase_nxt = phase;
        dummy_nxt = dummy_cnt;
        bad_nxt   = bad_cmd;
        reply_sel = REPLY_NONE;
        addr_load = 1'b0;

        if (rx_last) begin
            case (phase)
                PH_IDLE: begin
                    case (rx_byte)
                        CMD_READ_ID: begin
                            phase_nxt = PH_ID;
                            reply_sel = REPLY_ID;
                        end
                        CMD_FAST_READ: phase_nxt = PH_ADDR1;
                        CMD_WAKEUP:    phase_nxt = PH_IDLE;
                        // Flag it, then carry on as after a wake-up.
                        default:       bad_nxt = 1'b1;
                    endcase
                end
                PH_ADDR1, PH_ADDR2, PH_ADDR3: begin
                    addr_load = 1'b1;
                    if (phase == LAST_ADDR) begin
                        phase_nxt = PH_DUMMY;
                    end else begin
                        phase_nxt = flash_phase_e'(phase + 3'd1);
                    end
                end
                PH_DUMMY: begin
                    if (dummy_cnt == DUMMY_W'(DUMMY_BYTES - 1)) begin
                        phase_nxt = PH_DATA;
                        reply_sel = REPLY_DATA;
                    end else begin
                        dummy_nxt = dummy_cnt + 1'b1;
                    end
                end
                PH_DATA: reply_sel = REPLY_DATA;
                PH_ID:   reply_sel = REPLY_ID;
                default: phase_nxt = PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            phase     <= PH_IDLE;
            dummy_cnt <= '0;
            bad_cmd   <= 1'b0;
        end else begin
            phase     <= phase_nxt;
            dummy_cnt <= dummy_nxt;
            bad_cmd   <= bad_nxt;
        end
    end

endmodule

/* logic/id_source.sv */
`timescale 1ns/1ps

`include "spi_flash_config.svh"

module id_source
    import spi_flash_pkg::*;
(
    input  logic     sclk,
    input  logic     cs,
    input  logic     advance,
    output tx_byte_t id_req
);

    localparam logic [23:0] ID_CODE = `FLASH_ID_CODE;

    logic [1:0] idx;

    // Index 0 is the top byte; wraps after index 2.
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            idx <= 2'd0;
        end else if (advance) begin
            if (idx == 2'd2) begin
                idx <= 2'd0;
            end else begin
                idx <= idx + 2'd1;
            end
        end
    end

    always_comb begin
        case (idx)
            2'd0:    id_req.data = ID_CODE[23:16];
            2'd1:    id_req.data = ID_CODE[15:8];
            default: id_req.data = ID_CODE[7:0];
        endcase
    end

    // ID bytes are always on hand.
    assign id_req.req = 1'b1;

endmodule

/* logic/pattern_source.sv */
`timescale 1ns/1ps

`include "spi_flash_config.svh"

module pattern_source
    import spi_flash_pkg::*;
(
    input  logic       sclk,
    input  logic       cs,
    input  logic       addr_load,
    input  logic [7:0] rx_byte,
    input  logic       advance,
    output tx_byte_t   data_req
);

    localparam int ADDR_BYTES = `FLASH_ADDR_BYTES;
    localparam int ADDR_W     = 8 * ADDR_BYTES;
    localparam int CNT_W      = $clog2(ADDR_BYTES + 1);

    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  addr_cnt;
    logic [7:0]        pattern;

    // Address arrives MSB first, then counts up per data byte.
    always_ff @(posedge sclk) begin
        if (addr_load) begin
            addr <= {addr[ADDR_W-9:0], rx_byte};
        end else if (advance) begin
            addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            addr_cnt <= '0;
        end else if (addr_load && addr_cnt != CNT_W'(ADDR_BYTES)) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // XOR of all address bytes.
    always_comb begin
        pattern = 8'h00;
        for (int i = 0; i < ADDR_BYTES; i++) begin
            pattern = pattern ^ addr[8*i +: 8];
        end
    end

    assign data_req.req  = (addr_cnt == CNT_W'(ADDR_BYTES));
    assign data_req.data = pattern;

endmodule

/* logic/reply_arbiter.sv */
`timescale 1ns/1ps

module reply_arbiter
    import spi_flash_pkg::*;
(
    input  logic       sclk,
    input  logic       cs,
    input  logic       rx_last,
    input  reply_sel_e reply_sel,
    input  tx_byte_t   data_req,
    input  tx_byte_t   id_req,
    output logic       tx_load,
    output logic [7:0] tx_data,
    output logic       data_advance,
    output logic       id_advance,
    output logic       so_en
);

    logic data_grant;
    logic id_grant;

    // **************************************************************************
    // One grant per byte boundary
    // **************************************************************************

    // Decoder selects the kind, the source must also be ready.
    assign data_grant = rx_last && (reply_sel == REPLY_DATA) && data_req.req;
    assign id_grant   = rx_last && (reply_sel == REPLY_ID) && id_req.req;

    assign tx_load = data_grant | id_grant;

    always_comb begin
        if (id_grant) begin
            tx_data = id_req.data;
        end else begin
            tx_data = data_req.data;
        end
    end

    // Granted source steps on the loading edge.
    assign data_advance = data_grant;
    assign id_advance   = id_grant;

    // **************************************************************************
    // Output enable
    // **************************************************************************

    // Sticky from the first load until cs rises.
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            so_en <= 1'b0;
        end else if (tx_load) begin
            so_en <= 1'b1;
        end
    end

endmodule

/* logic/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic       sclk,
    input  logic       cs,
    input  logic       si,
    input  logic       tx_load,
    input  logic [7:0] tx_data,
    output logic [7:0] rx_byte,
    output logic       rx_last,
    output logic       so
);

    logic [2:0] bit_cnt;
    logic [6:0] rx_reg;
    logic [7:0] tx_reg;

    // **************************************************************************
    // Receive side
    // **************************************************************************

    // Bit position inside the current byte.
    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            bit_cnt <= 3'd0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // Earlier bits of the byte, oldest on top.
    always_ff @(posedge sclk) begin
        rx_reg <= {rx_reg[5:0], si};
    end

    // Live si closes the byte.
    assign rx_byte = {rx_reg, si};
    assign rx_last = (bit_cnt == 3'd7);

    // **************************************************************************
    // Transmit side
    // **************************************************************************

    always_ff @(posedge sclk or posedge cs) begin
        if (cs) begin
            tx_reg <= 8'h00;
        end else if (tx_load) begin
            tx_reg <= tx_data;
        end else begin
            tx_reg <= {tx_reg[6:0], 1'b0};
        end
    end

    // MSB first.
    assign so = tx_reg[7];

endmodule

/* logic/spi_flash_config.svh */
`ifndef SPI_FLASH_CONFIG_SVH
`define SPI_FLASH_CONFIG_SVH

// Identification code, sent most significant byte first.
`define FLASH_ID_CODE 24'h010000

// Address bytes after the fast read command.
`define FLASH_ADDR_BYTES 3

// Dummy bytes between address and data.
`define FLASH_DUMMY_BYTES 1

`endif

/* logic/spi_flash_pkg.sv */
package spi_flash_pkg;

    // **************************************************************************
    // Command codes
    // **************************************************************************

    typedef enum logic [7:0] {
        CMD_FAST_READ = 8'h0B,
        CMD_READ_ID   = 8'h9F,
        CMD_WAKEUP    = 8'hAB
    } flash_cmd_e;

    // **************************************************************************
    // Decoder phases and reply kinds
    // **************************************************************************

    // Address phases must stay consecutive from PH_ADDR1.
    typedef enum logic [2:0] {
        PH_IDLE  = 3'd0,
        PH_ADDR1 = 3'd1,
        PH_ADDR2 = 3'd2,
        PH_ADDR3 = 3'd3,
        PH_DUMMY = 3'd4,
        PH_DATA  = 3'd5,
        PH_ID    = 3'd6
    } flash_phase_e;

    typedef enum logic [1:0] {
        REPLY_NONE = 2'd0,
        REPLY_DATA = 2'd1,
        REPLY_ID   = 2'd2
    } reply_sel_e;

    // Byte offered by a reply source.
    typedef struct packed {
        logic       req;
        logic [7:0] data;
    } tx_byte_t;

endpackage

/* logic/spi_flash_responder.sv */
`timescale 1ns/1ps

module spi_flash_responder
    import spi_flash_pkg::*;
(
    input  logic sclk,
    input  logic cs,
    input  logic si,
    output logic so,
    output logic so_en,
    output logic bad_cmd
);

    logic [7:0] rx_byte;
    logic       rx_last;
    logic       tx_load;
    logic [7:0] tx_data;
    reply_sel_e reply_sel;
    logic       addr_load;
    tx_byte_t   data_req;
    tx_byte_t   id_req;
    logic       data_advance;
    logic       id_advance;

    spi_byte_shifter u_shifter (
        .sclk    (sclk),
        .cs      (cs),
        .si      (si),
        .tx_load (tx_load),
        .tx_data (tx_data),
        .rx_byte (rx_byte),
        .rx_last (rx_last),
        .so      (so)
    );

    flash_cmd_decoder u_decoder (
        .sclk      (sclk),
        .cs        (cs),
        .rx_byte   (rx_byte),
        .rx_last   (rx_last),
        .reply_sel (reply_sel),
        .addr_load (addr_load),
        .bad_cmd   (bad_cmd)
    );

    // **************************************************************************
    // Reply sources and their arbiter
    // **************************************************************************

    pattern_source u_pattern (
        .sclk      (sclk),
        .cs        (cs),
        .addr_load (addr_load),
        .rx_byte   (rx_byte),
        .advance   (data_advance),
        .data_req  (data_req)
    );

    id_source u_id (
        .sclk    (sclk),
        .cs      (cs),
        .advance (id_advance),
        .id_req  (id_req)
    );

    reply_arbiter u_arbiter (
        .sclk         (sclk),
        .cs           (cs),
        .rx_last      (rx_last),
        .reply_sel    (reply_sel),
        .data_req     (data_req),
        .id_req       (id_req),
        .tx_load      (tx_load),
        .tx_data      (tx_data),
        .data_advance (data_advance),
        .id_advance   (id_advance),
        .so_en        (so_en)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module spi_flash_responder_tb \
    -f spi_flash_responder.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* spi_flash_responder.f */
+incdir+logic
+incdir+tb
logic/spi_flash_pkg.sv
logic/spi_byte_shifter.sv
logic/flash_cmd_decoder.sv
logic/pattern_source.sv
logic/id_source.sv
logic/reply_arbiter.sv
logic/spi_flash_responder.sv
tb/spi_flash_responder_tb.sv

/* tb/spi_master_tasks.svh */
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// Starts a transaction; returns on a falling edge.
task automatic select_flash();
    @(negedge sclk);
    cs = 1'b0;
endtask

task automatic release_flash();
    cs = 1'b1;
    si = 1'b0;
    repeat (2) @(negedge sclk);
endtask

// MSB first. so is taken on each falling edge before si moves.
task automatic transfer_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx,
                             output logic en_all, output logic en_any);
    rx     = 8'h00;
    en_all = 1'b1;
    en_any = 1'b0;
    for (int i = 7; i > 7 - nbits; i--) begin
        rx[i]  = so;
        en_all = en_all & so_en;
        en_any = en_any | so_en;
        si     = tx[i];
        @(negedge sclk);
    end
endtask

task automatic reset_state_test();
    logic [7:0] rx;
    logic       en_all;
    logic       en_any;
    compare_byte("so_en after reset", {7'd0, so_en}, 8'h00);
    compare_byte("bad_cmd after reset", {7'd0, bad_cmd}, 8'h00);
    select_flash();
    transfer_bits(CMD_READ_ID, 8, rx, en_all, en_any);
    compare_byte("so_en in first byte", {7'd0, en_any}, 8'h00);
    compare_byte("bad_cmd after read id", {7'd0, bad_cmd}, 8'h00);
    release_flash();
endtask

task automatic id_reply(input int nbytes);
    logic [7:0] rx;
    logic       en_all;
    logic       en_any;
    for (int k = 0; k < nbytes; k++) begin
        transfer_bits(8'h00, 8, rx, en_all, en_any);
        compare_byte($sformatf("id byte %0d", k), rx, expected_id_byte(k));
        compare_byte("so_en in id reply", {7'd0, en_all}, 8'h01);
    end
endtask

task automatic read_id_test();
    logic [7:0] rx;
    logic       en_all;
    logic       en_any;
    select_flash();
    transfer_bits(CMD_READ_ID, 8, rx, en_all, en_any);
    id_reply(9);
    release_flash();
endtask

task automatic fast_read_at(input logic [23:0] base, input int nbytes);
    logic [7:0] rx;
    logic       en_all;
    logic       en_any;
    select_flash();
    transfer_bits(CMD_FAST_READ, 8, rx, en_all, en_any);
    for (int b = 2; b >= 0; b--) begin
        transfer_bits(base[8*b +: 8], 8, rx, en_all, en_any);
    end
    transfer_bits(8'h00, 8, rx, en_all, en_any);
    for (int k = 0; k < nbytes; k++) begin
        transfer_bits(8'h00, 8, rx, en_all, en_any);
        compare_byte($sformatf("data %0d at %06h", k, base), rx, expected_pattern(base, k));
    end
    release_flash();
endtask

task automatic fast_read_test();
    logic [31:0] rnd;
    rnd = $random(seed);
    fast_read_at(rnd[23:0], 16);
endtask

task automatic address_carry_test();
    fast_read_at(24'h00FFFE, 4);
endtask

task automatic wakeup_bad_cmd_test();
    logic [7:0] rx;
    logic       en_all;
    logic       en_any;
    select_flash();
    transfer_bits(CMD_WAKEUP, 8, rx, en_all, en_any);
    compare_byte("bad_cmd after wake-up", {7'd0, bad_cmd}, 8'h00);
    transfer_bits(CMD_READ_ID, 8, rx, en_all, en_any);
    compare_byte("so_en after wake-up", {7'd0, en_any}, 8'h00);
    id_reply(3);
    release_flash();
    // Unknown byte, then decoding goes on as after a wake-up.
    select_flash();
    transfer_bits(8'h55, 8, rx, en_all, en_any);
    compare_byte("bad_cmd after 55", {7'd0, bad_cmd}, 8'h01);
    transfer_bits(CMD_READ_ID, 8, rx, en_all, en_any);
    compare_byte("so_en after 55", {7'd0, en_any}, 8'h00);
    id_reply(3);
    compare_byte("bad_cmd held", {7'd0, bad_cmd}, 8'h01);
    release_flash();
    compare_byte("bad_cmd after cs", {7'd0, bad_cmd}, 8'h00);
    read_id_test();
endtask

task automatic aborted_read_test();
    logic [7:0]  rx;
    logic        en_all;
    logic        en_any;
    logic [31:0] rnd;
    select_flash();
    transfer_bits(CMD_FAST_READ, 8, rx, en_all, en_any);
    transfer_bits(8'h12, 8, rx, en_all, en_any);
    transfer_bits(8'h34, 4, rx, en_all, en_any);
    release_flash();
    rnd = $random(seed);
    fast_read_at(rnd[23:0], 4);
endtask

`endif

/* tb/spi_flash_responder_tb.sv */
`timescale 1ns/1ps

`include "spi_flash_config.svh"

module spi_flash_responder_tb
    import spi_flash_pkg::*;
();

    // Whole test sequence runs well under this.
    localparam int TIMEOUT_CYCLES = 4000;

    logic   sclk;
    logic   cs;
    logic   si;
    logic   so;
    logic   so_en;
    logic   bad_cmd;
    int     errors = 0;
    int     cycles = 0;
    integer seed;

    spi_flash_responder dut (
        .sclk    (sclk),
        .cs      (cs),
        .si      (si),
        .so      (so),
        .so_en   (so_en),
        .bad_cmd (bad_cmd)
    );

    initial sclk = 1'b0;
    always #5 sclk = ~sclk;

    always @(posedge sclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // **************************************************************************
    // Checks and reference model
    // **************************************************************************

    task automatic compare_byte(input string what, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // Data byte k of a fast read is the XOR of the bytes of base + k.
    function automatic logic [7:0] expected_pattern(input logic [23:0] base, input int k);
        logic [23:0] a;
        a = base + 24'(k);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    // ID bytes repeat every three, top byte first.
    function automatic logic [7:0] expected_id_byte(input int k);
        logic [23:0] id;
        id = `FLASH_ID_CODE;
        return id[8*(2 - k % 3) +: 8];
    endfunction

    `include "spi_master_tasks.svh"

    initial begin
        cs   = 1'b1;
        si   = 1'b0;
        seed = 32'hcfaf_0085;
        repeat (2) @(negedge sclk);

        reset_state_test();
        read_id_test();
        fast_read_test();
        address_carry_test();
        wakeup_bad_cmd_test();
        aborted_read_test();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
